// File: design/sdram_pkg.sv
package sdram_pkg;

//////////////////////////////
// Avalon-MM read port widths
//////////////////////////////

// Word address, one unit per 128-bit word
localparam int SDRAM_AW = 24;

// Read data width
localparam int SDRAM_W = 128;

//////////////////////////////
// Port types
//////////////////////////////

// Word address as seen on o_sdram_address
typedef logic [SDRAM_AW - 1 : 0] sdram_addr_t;

// One full read word, eight 16-bit lanes packed low to high
typedef logic [SDRAM_W - 1 : 0] sdram_word_t;

endpackage

// File: design/eu_pkg.sv
package eu_pkg;

//////////////////////////////
// Execution group sizing
//////////////////////////////

// Sub-units per group
localparam int STMM_SUB_NUM = 4;

// Lanes per operand word and their width
localparam int LANES  = 8;
localparam int LANE_W = 16;

// 32-bit product plus 3 bits of growth for eight terms
localparam int ACC_W = 35;

// Execute pipeline depth, strobe to done
localparam int EXEC_LAT = 3;

//////////////////////////////
// Types
//////////////////////////////

// Bit k selects sub-unit k
typedef logic [STMM_SUB_NUM - 1 : 0] sub_mask_t;
typedef logic [$clog2(STMM_SUB_NUM) - 1 : 0] sub_idx_t;

typedef logic signed [LANE_W - 1 : 0] lane_t;
typedef logic signed [ACC_W - 1 : 0] acc_t;

// Fetch engine states
typedef enum logic [2 : 0] {
    FETCH_IDLE,
    FETCH_SCAN,
    FETCH_REQ,
    FETCH_WAIT,
    FETCH_DONE
} fetch_state_t;

endpackage

// File: design/stmm_fetch.sv
`timescale 1ns/10ps

module stmm_fetch (
    input  logic                   clk,
    input  logic                   i_rst,

    // Control unit
    input  eu_pkg::sub_mask_t      i_fetch,
    input  logic                   i_fetch_valid,
    input  sdram_pkg::sdram_addr_t i_fetch_addr,

    // Avalon-MM read master
    output sdram_pkg::sdram_addr_t o_sdram_address,
    output logic                   o_sdram_read,
    input  logic                   i_sdram_waitrequest,
    input  sdram_pkg::sdram_word_t i_sdram_readdata,
    input  logic                   i_sdram_readdatavalid,

    // Operand loads towards the sub-units
    output logic                   o_load_a,
    output logic                   o_load_b,
    output eu_pkg::sub_idx_t       o_load_idx,
    output sdram_pkg::sdram_word_t o_load_data,

    // Status
    output logic                   o_fetch_busy,
    output logic                   o_fetch_done
);

eu_pkg::fetch_state_t   state;
eu_pkg::sub_mask_t      mask_q;
sdram_pkg::sdram_addr_t base_q;
sdram_pkg::sdram_addr_t addr_q;
eu_pkg::sub_idx_t       cur_idx;
logic                   sel_b;

eu_pkg::sub_idx_t       scan_idx;
logic                   word_back;

//////////////////////////////
// Next sub-unit to serve
//////////////////////////////

// Lowest set bit wins, so sub-units are served in rising order
always_comb begin
    scan_idx = '0;
    for (int k = eu_pkg::STMM_SUB_NUM - 1; k >= 0; k--) begin
        if (mask_q[k]) begin
            scan_idx = eu_pkg::sub_idx_t'(k);
        end
    end
end

//////////////////////////////
// Fetch FSM
//////////////////////////////

always_ff @(posedge clk) begin
    if (i_rst) begin
        state  <= eu_pkg::FETCH_IDLE;
        mask_q <= '0;
        sel_b  <= 1'b0;
    end else begin
        case (state)
            eu_pkg::FETCH_IDLE: begin
                if (i_fetch_valid) begin
                    mask_q <= i_fetch;
                    base_q <= i_fetch_addr;
                    state  <= eu_pkg::FETCH_SCAN;
                end
            end
            eu_pkg::FETCH_SCAN: begin
                if (mask_q == '0) begin
                    state <= eu_pkg::FETCH_DONE;
                end else begin
                    // A word at base + 2k, B word right after it
                    cur_idx <= scan_idx;
                    addr_q  <= base_q + sdram_pkg::sdram_addr_t'({scan_idx, 1'b0});
                    sel_b   <= 1'b0;
                    state   <= eu_pkg::FETCH_REQ;
                end
            end
            eu_pkg::FETCH_REQ: begin
                // Request held until the slave drops waitrequest
                if (!i_sdram_waitrequest) begin
                    state <= eu_pkg::FETCH_WAIT;
                end
            end
            eu_pkg::FETCH_WAIT: begin
                if (i_sdram_readdatavalid) begin
                    if (!sel_b) begin
                        sel_b  <= 1'b1;
                        addr_q <= addr_q + 1'b1;
                        state  <= eu_pkg::FETCH_REQ;
                    end else begin
                        mask_q[cur_idx] <= 1'b0;
                        state           <= eu_pkg::FETCH_SCAN;
                    end
                end
            end
            eu_pkg::FETCH_DONE: begin
                state <= eu_pkg::FETCH_IDLE;
            end
            default: begin
                state <= eu_pkg::FETCH_IDLE;
            end
        endcase
    end
end

//////////////////////////////
// Outputs
//////////////////////////////

assign o_sdram_read    = (state == eu_pkg::FETCH_REQ);
assign o_sdram_address = addr_q;

// Returned word goes straight to the selected operand register
assign word_back   = (state == eu_pkg::FETCH_WAIT) && i_sdram_readdatavalid;
assign o_load_a    = word_back && !sel_b;
assign o_load_b    = word_back && sel_b;
assign o_load_idx  = cur_idx;
assign o_load_data = i_sdram_readdata;

assign o_fetch_busy = (state != eu_pkg::FETCH_IDLE);
assign o_fetch_done = (state == eu_pkg::FETCH_DONE);

endmodule

// File: design/stmm_sub.sv
`timescale 1ns/10ps

module stmm_sub (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_load_a,
    input  logic                   i_load_b,
    input  sdram_pkg::sdram_word_t i_load_data,
    input  logic                   i_exec,
    output logic                   o_exec_done,
    output eu_pkg::acc_t           o_result
);

sdram_pkg::sdram_word_t a_q;
sdram_pkg::sdram_word_t b_q;

eu_pkg::lane_t lane_a [eu_pkg::LANES];
eu_pkg::lane_t lane_b [eu_pkg::LANES];

eu_pkg::acc_t prod_q [eu_pkg::LANES];
eu_pkg::acc_t sum_lo_q;
eu_pkg::acc_t sum_hi_q;

// One valid bit per pipeline stage
logic [eu_pkg::EXEC_LAT - 1 : 0] vld_q;

//////////////////////////////
// Operand registers
//////////////////////////////

always_ff @(posedge clk) begin
    if (i_rst) begin
        a_q <= '0;
        b_q <= '0;
    end else begin
        if (i_load_a) a_q <= i_load_data;
        if (i_load_b) b_q <= i_load_data;
    end
end

// Lane 0 sits in the low bits
always_comb begin
    for (int i = 0; i < eu_pkg::LANES; i++) begin
        lane_a[i] = eu_pkg::lane_t'(a_q[i * eu_pkg::LANE_W +: eu_pkg::LANE_W]);
        lane_b[i] = eu_pkg::lane_t'(b_q[i * eu_pkg::LANE_W +: eu_pkg::LANE_W]);
    end
end

//////////////////////////////
// Dot product pipeline
//////////////////////////////

// Stage 1, lane products
always_ff @(posedge clk) begin
    if (i_exec) begin
        for (int i = 0; i < eu_pkg::LANES; i++) begin
            prod_q[i] <= lane_a[i] * lane_b[i];
        end
    end
end

// Stage 2, two half sums
always_ff @(posedge clk) begin
    eu_pkg::acc_t lo;
    eu_pkg::acc_t hi;
    lo = '0;
    hi = '0;
    for (int i = 0; i < eu_pkg::LANES / 2; i++) begin
        lo = lo + prod_q[i];
        hi = hi + prod_q[i + eu_pkg::LANES / 2];
    end
    if (vld_q[0]) begin
        sum_lo_q <= lo;
        sum_hi_q <= hi;
    end
end

// Stage 3, result register holds until the next execute
always_ff @(posedge clk) begin
    if (i_rst) begin
        o_result <= '0;
    end else if (vld_q[1]) begin
        o_result <= sum_lo_q + sum_hi_q;
    end
end

always_ff @(posedge clk) begin
    if (i_rst) begin
        vld_q <= '0;
    end else begin
        vld_q <= {vld_q[eu_pkg::EXEC_LAT - 2 : 0], i_exec};
    end
end

assign o_exec_done = vld_q[eu_pkg::EXEC_LAT - 1];

endmodule

// File: design/stmm_wrapper.sv
`timescale 1ns/10ps

module stmm_wrapper (
    input  logic                   clk,
    input  logic                   i_rst,

    // Operand loads from the fetch engine
    input  logic                   i_load_a,
    input  logic                   i_load_b,
    input  eu_pkg::sub_idx_t       i_load_idx,
    input  sdram_pkg::sdram_word_t i_load_data,

    // Execute command
    input  eu_pkg::sub_mask_t      i_exec,
    input  logic                   i_exec_valid,

    // Per sub-unit status and results
    output eu_pkg::sub_mask_t      o_exec_done,
    output eu_pkg::acc_t [eu_pkg::STMM_SUB_NUM - 1 : 0] o_result
);

eu_pkg::sub_mask_t load_a_vec;
eu_pkg::sub_mask_t load_b_vec;
eu_pkg::sub_mask_t exec_vec;

//////////////////////////////
// Strobe routing
//////////////////////////////

// Only the indexed sub-unit takes the word
always_comb begin
    for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
        load_a_vec[k] = i_load_a && (i_load_idx == eu_pkg::sub_idx_t'(k));
        load_b_vec[k] = i_load_b && (i_load_idx == eu_pkg::sub_idx_t'(k));
    end
end

assign exec_vec = i_exec & {eu_pkg::STMM_SUB_NUM{i_exec_valid}};

//////////////////////////////
// Sub-units
//////////////////////////////

for (genvar k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin : g_sub
    stmm_sub i_stmm_sub (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_load_a    (load_a_vec[k]),
        .i_load_b    (load_b_vec[k]),
        .i_load_data (i_load_data),
        .i_exec      (exec_vec[k]),
        .o_exec_done (o_exec_done[k]),
        .o_result    (o_result[k])
    );
end

endmodule

// File: design/eu_top.sv
`timescale 1ns/10ps

module eu_top (
    input  logic                   clk,
    input  logic                   i_rst,

    // Avalon-MM read master
    output sdram_pkg::sdram_addr_t o_sdram_address,
    output logic                   o_sdram_read,
    input  logic                   i_sdram_waitrequest,
    input  sdram_pkg::sdram_word_t i_sdram_readdata,
    input  logic                   i_sdram_readdatavalid,

    // Control unit commands
    input  eu_pkg::sub_mask_t      i_eu_fetch,
    input  logic                   i_eu_fetch_valid,
    input  sdram_pkg::sdram_addr_t i_eu_fetch_addr,
    input  eu_pkg::sub_mask_t      i_eu_exec,
    input  logic                   i_eu_exec_valid,

    // Status and results
    output logic                   o_fetch_busy,
    output logic                   o_fetch_done,
    output eu_pkg::sub_mask_t      o_exec_done,
    output eu_pkg::acc_t [eu_pkg::STMM_SUB_NUM - 1 : 0] o_result
);

// Fetch engine to sub-unit operand loads
logic                   load_a;
logic                   load_b;
eu_pkg::sub_idx_t       load_idx;
sdram_pkg::sdram_word_t load_data;

//////////////////////////////
// Input side
//////////////////////////////

stmm_fetch i_stmm_fetch (
    .clk                   (clk),
    .i_rst                 (i_rst),
    .i_fetch               (i_eu_fetch),
    .i_fetch_valid         (i_eu_fetch_valid),
    .i_fetch_addr          (i_eu_fetch_addr),
    .o_sdram_address       (o_sdram_address),
    .o_sdram_read          (o_sdram_read),
    .i_sdram_waitrequest   (i_sdram_waitrequest),
    .i_sdram_readdata      (i_sdram_readdata),
    .i_sdram_readdatavalid (i_sdram_readdatavalid),
    .o_load_a              (load_a),
    .o_load_b              (load_b),
    .o_load_idx            (load_idx),
    .o_load_data           (load_data),
    .o_fetch_busy          (o_fetch_busy),
    .o_fetch_done          (o_fetch_done)
);

//////////////////////////////
// Execution group
//////////////////////////////

stmm_wrapper i_stmm_wrapper (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_load_a     (load_a),
    .i_load_b     (load_b),
    .i_load_idx   (load_idx),
    .i_load_data  (load_data),
    .i_exec       (i_eu_exec),
    .i_exec_valid (i_eu_exec_valid),
    .o_exec_done  (o_exec_done),
    .o_result     (o_result)
);

endmodule

// File: tb/sdram_model.sv
`timescale 1ns/10ps

module sdram_model (
    input  logic                   clk,
    input  logic                   i_rst,
    input  sdram_pkg::sdram_addr_t i_address,
    input  logic                   i_read,
    output logic                   o_waitrequest,
    output sdram_pkg::sdram_word_t o_readdata,
    output logic                   o_readdatavalid
);

// Read in flight and cycles left until its data
logic                   pend;
int                     wait_cnt;
sdram_pkg::sdram_addr_t addr_q;

initial begin
    o_waitrequest   = 1'b1;
    o_readdata      = '0;
    o_readdatavalid = 1'b0;
    pend            = 1'b0;
    wait_cnt        = 0;
    addr_q          = '0;
end

//////////////////////////////
// Avalon-MM read slave
//////////////////////////////

always @(posedge clk) begin
    logic [31:0] lat;
    o_readdatavalid <= 1'b0;
    if (i_rst) begin
        pend = 1'b0;
    end else if (pend) begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0) begin
            pend = 1'b0;
            o_readdata      <= eu_top_tb.mem_word(addr_q);
            o_readdatavalid <= 1'b1;
        end
    end else if (i_read && !o_waitrequest) begin
        // Data comes back 1 to 4 cycles after the accepting cycle
        lat    = eu_top_tb.take_bits(2) + 32'd1;
        addr_q = i_address;
        if (lat == 32'd1) begin
            o_readdata      <= eu_top_tb.mem_word(addr_q);
            o_readdatavalid <= 1'b1;
        end else begin
            pend     = 1'b1;
            wait_cnt = int'(lat) - 1;
        end
    end
    // New stall decision every cycle, high half the time
    o_waitrequest <= eu_top_tb.lfsr_bit();
end

endmodule

// File: tb/eu_top_tb.sv
`timescale 1ns/10ps

module eu_top_tb;

localparam int NUM_CMDS     = 200;
localparam int RESET_CYCLES = 8;
// Eight reads of twelve cycles each per command and some overhead
localparam int TIMEOUT_CYCLES = NUM_CMDS * (8 * 12 + 10) + RESET_CYCLES;

logic                   clk;
logic                   rst;
sdram_pkg::sdram_addr_t sdram_address;
logic                   sdram_read;
logic                   sdram_waitrequest;
sdram_pkg::sdram_word_t sdram_readdata;
logic                   sdram_readdatavalid;
eu_pkg::sub_mask_t      eu_fetch;
logic                   eu_fetch_valid;
sdram_pkg::sdram_addr_t eu_fetch_addr;
eu_pkg::sub_mask_t      eu_exec;
logic                   eu_exec_valid;
logic                   fetch_busy;
logic                   fetch_done;
eu_pkg::sub_mask_t      exec_done;
eu_pkg::acc_t [eu_pkg::STMM_SUB_NUM - 1 : 0] result;

logic [31:0] lfsr = 32'd4;
sdram_pkg::sdram_word_t mem [sdram_pkg::sdram_addr_t];

// Pre-built command list
logic [1:0]             cmd_kind  [NUM_CMDS];
eu_pkg::sub_mask_t      cmd_fmask [NUM_CMDS];
eu_pkg::sub_mask_t      cmd_emask [NUM_CMDS];
sdram_pkg::sdram_addr_t cmd_addr  [NUM_CMDS];
logic [1:0]             cmd_gap   [NUM_CMDS];
logic                   cmd_wait  [NUM_CMDS];

// Reference model state
sdram_pkg::sdram_word_t op_a    [eu_pkg::STMM_SUB_NUM];
sdram_pkg::sdram_word_t op_b    [eu_pkg::STMM_SUB_NUM];
eu_pkg::acc_t           res_exp [eu_pkg::STMM_SUB_NUM];
sdram_pkg::sdram_addr_t rd_addr_q [$];
eu_pkg::sub_idx_t       rd_idx_q  [$];
logic                   rd_b_q    [$];
int                     due_q     [$];
eu_pkg::sub_mask_t      emask_q   [$];
eu_pkg::acc_t           eres_q    [$];
logic                   out_valid  = 1'b0;
logic                   out_b      = 1'b0;
eu_pkg::sub_idx_t       out_idx    = '0;
sdram_pkg::sdram_addr_t out_addr   = '0;
logic                   fetch_open = 1'b0;
logic                   prev_stall = 1'b0;
int                     cycle      = 0;

eu_top u_eu_top (
    .clk                   (clk),
    .i_rst                 (rst),
    .o_sdram_address       (sdram_address),
    .o_sdram_read          (sdram_read),
    .i_sdram_waitrequest   (sdram_waitrequest),
    .i_sdram_readdata      (sdram_readdata),
    .i_sdram_readdatavalid (sdram_readdatavalid),
    .i_eu_fetch            (eu_fetch),
    .i_eu_fetch_valid      (eu_fetch_valid),
    .i_eu_fetch_addr       (eu_fetch_addr),
    .i_eu_exec             (eu_exec),
    .i_eu_exec_valid       (eu_exec_valid),
    .o_fetch_busy          (fetch_busy),
    .o_fetch_done          (fetch_done),
    .o_exec_done           (exec_done),
    .o_result              (result)
);

sdram_model u_sdram_model (
    .clk             (clk),
    .i_rst           (rst),
    .i_address       (sdram_address),
    .i_read          (sdram_read),
    .o_waitrequest   (sdram_waitrequest),
    .o_readdata      (sdram_readdata),
    .o_readdatavalid (sdram_readdatavalid)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

//////////////////////////////
// Random source and memory
//////////////////////////////

// Galois LFSR stepped once per bit
function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h8020_0003;
    return out;
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
endfunction

task automatic fill_word(input sdram_pkg::sdram_addr_t addr);
    sdram_pkg::sdram_word_t w;
    if (!mem.exists(addr)) begin
        for (int i = 0; i < 4; i++) w[i * 32 +: 32] = take_bits(32);
        mem[addr] = w;
    end
endtask

function automatic sdram_pkg::sdram_word_t mem_word(input sdram_pkg::sdram_addr_t addr);
    if (mem.exists(addr)) return mem[addr];
    return '0;
endfunction

function automatic eu_pkg::acc_t dot_product(input sdram_pkg::sdram_word_t a,
                                             input sdram_pkg::sdram_word_t b);
    longint        sum;
    eu_pkg::lane_t la;
    eu_pkg::lane_t lb;
    sum = 0;
    for (int i = 0; i < eu_pkg::LANES; i++) begin
        la  = a[i * eu_pkg::LANE_W +: eu_pkg::LANE_W];
        lb  = b[i * eu_pkg::LANE_W +: eu_pkg::LANE_W];
        sum = sum + longint'(la) * longint'(lb);
    end
    return eu_pkg::acc_t'(sum);
endfunction

task automatic make_commands();
    for (int c = 0; c < NUM_CMDS; c++) begin
        cmd_kind[c]  = 2'(take_bits(2));
        cmd_fmask[c] = eu_pkg::sub_mask_t'(take_bits(eu_pkg::STMM_SUB_NUM));
        cmd_emask[c] = eu_pkg::sub_mask_t'(take_bits(eu_pkg::STMM_SUB_NUM));
        cmd_addr[c]  = sdram_pkg::sdram_addr_t'(take_bits(sdram_pkg::SDRAM_AW));
        cmd_gap[c]   = 2'(take_bits(2));
        cmd_wait[c]  = take_bits(1) != 0;
        for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
            if (cmd_fmask[c][k]) begin
                fill_word(cmd_addr[c] + sdram_pkg::sdram_addr_t'(2 * k));
                fill_word(cmd_addr[c] + sdram_pkg::sdram_addr_t'(2 * k + 1));
            end
        end
    end
endtask

//////////////////////////////
// Error reporting
//////////////////////////////

task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    stop_run();
endtask

task automatic check_result(input string name, input eu_pkg::acc_t exp, input eu_pkg::acc_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        stop_run();
    end
endtask

task automatic check_mask(input string name, input eu_pkg::sub_mask_t exp,
                          input eu_pkg::sub_mask_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected %b, actual %b", name, exp, act);
        stop_run();
    end
endtask

task automatic check_addr(input string name, input sdram_pkg::sdram_addr_t exp,
                          input sdram_pkg::sdram_addr_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        stop_run();
    end
endtask

//////////////////////////////
// Monitor and reference model
//////////////////////////////

always @(posedge clk) begin
    eu_pkg::sub_mask_t want_done;
    eu_pkg::acc_t      want_res;
    logic              fetch_idle;
    cycle = cycle + 1;
    if (cycle > TIMEOUT_CYCLES) begin
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end
    if (!rst) begin
        if (sdram_read && !fetch_open) report_problem("o_sdram_read high with no fetch running");
        if (prev_stall) begin
            if (!sdram_read) report_problem("o_sdram_read dropped while waitrequest was high");
            if (rd_addr_q.size() == 0) report_problem("SDRAM read held with none expected");
            check_addr("held address", rd_addr_q[0], sdram_address);
        end
        if (sdram_read && !sdram_waitrequest) begin
            if (rd_addr_q.size() == 0) report_problem("SDRAM read issued with none expected");
            if (out_valid) report_problem("second SDRAM read while one is outstanding");
            check_addr("read address", rd_addr_q[0], sdram_address);
            out_valid = 1'b1;
            out_addr  = rd_addr_q.pop_front();
            out_idx   = rd_idx_q.pop_front();
            out_b     = rd_b_q.pop_front();
        end
        prev_stall = sdram_read && sdram_waitrequest;

        // Execute results due in this cycle
        want_done = '0;
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            void'(due_q.pop_front());
            want_done = emask_q.pop_front();
            for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
                want_res = eres_q.pop_front();
                if (want_done[k]) res_exp[k] = want_res;
            end
        end
        check_mask("exec done", want_done, exec_done);
        for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
            check_result($sformatf("result %0d", k), res_exp[k], result[k]);
        end
        if (eu_exec_valid) begin
            due_q.push_back(cycle + eu_pkg::EXEC_LAT);
            emask_q.push_back(eu_exec);
            for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
                eres_q.push_back(dot_product(op_a[k], op_b[k]));
            end
        end

        // A word loaded now is only seen by later executes
        if (sdram_readdatavalid) begin
            if (!out_valid) report_problem("read data returned with no read outstanding");
            if (out_b) op_b[out_idx] = mem_word(out_addr);
            else op_a[out_idx] = mem_word(out_addr);
            out_valid = 1'b0;
        end

        // Busy covers the done cycle, so a strobe there is dropped
        fetch_idle = !fetch_open;
        if (fetch_busy !== fetch_open) report_problem("o_fetch_busy does not match the fetch state");
        if (fetch_done) begin
            if (!fetch_open) report_problem("o_fetch_done without an accepted fetch");
            if (rd_addr_q.size() != 0 || out_valid) report_problem("o_fetch_done before last read");
            fetch_open = 1'b0;
        end
        if (eu_fetch_valid && fetch_idle) begin
            fetch_open = 1'b1;
            for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
                if (eu_fetch[k]) begin
                    rd_addr_q.push_back(eu_fetch_addr + sdram_pkg::sdram_addr_t'(2 * k));
                    rd_addr_q.push_back(eu_fetch_addr + sdram_pkg::sdram_addr_t'(2 * k + 1));
                    rd_idx_q.push_back(eu_pkg::sub_idx_t'(k));
                    rd_idx_q.push_back(eu_pkg::sub_idx_t'(k));
                    rd_b_q.push_back(1'b0);
                    rd_b_q.push_back(1'b1);
                end
            end
        end
    end
end

//////////////////////////////
// Stimulus
//////////////////////////////

task automatic wait_fetch_idle();
    @(posedge clk);
    eu_fetch_valid <= 1'b0;
    eu_exec_valid  <= 1'b0;
    @(posedge clk);
    while (fetch_busy) @(posedge clk);
endtask

initial begin
    rst            = 1'b1;
    eu_fetch       = '0;
    eu_fetch_valid = 1'b0;
    eu_fetch_addr  = '0;
    eu_exec        = '0;
    eu_exec_valid  = 1'b0;
    for (int k = 0; k < eu_pkg::STMM_SUB_NUM; k++) begin
        op_a[k]    = '0;
        op_b[k]    = '0;
        res_exp[k] = '0;
    end
    make_commands();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    // Kind bit 1 sends a fetch and every kind but 2'b10 sends an execute
    for (int c = 0; c < NUM_CMDS; c++) begin
        @(posedge clk);
        eu_fetch_valid <= cmd_kind[c][1];
        eu_exec_valid  <= !cmd_kind[c][1] || cmd_kind[c][0];
        eu_fetch       <= cmd_fmask[c];
        eu_fetch_addr  <= cmd_addr[c];
        eu_exec        <= cmd_emask[c];
        repeat (cmd_gap[c]) begin
            @(posedge clk);
            eu_fetch_valid <= 1'b0;
            eu_exec_valid  <= 1'b0;
        end
        if (cmd_wait[c] && cmd_kind[c][1]) wait_fetch_idle();
    end
    wait_fetch_idle();
    repeat (eu_pkg::EXEC_LAT + 1) @(posedge clk);

    if (rd_addr_q.size() != 0 || due_q.size() != 0 || fetch_open || out_valid) begin
        report_problem("run ended with reads or results still expected");
    end else begin
        $display("Result: PASSED");
        $finish;
    end
end

endmodule

// File: project.f
design/sdram_pkg.sv
design/eu_pkg.sv
design/stmm_fetch.sv
design/stmm_sub.sv
design/stmm_wrapper.sv
design/eu_top.sv
tb/sdram_model.sv
tb/eu_top_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the eu_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module eu_top_tb -f project.f -o Veu_top_tb

# The log decides the outcome
./obj_dir/Veu_top_tb 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
